/* hdl/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  localparam int DATA_W    = 8;
  localparam int BANK_W    = 2;
  localparam int ROW_W     = 4;
  localparam int ADDR_W    = ROW_W + BANK_W; // Row in the high bits, bank in the low bits
  localparam int NUM_BANKS = 4;
  localparam int NUM_ROWS  = 16;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BANK_W-1:0] bank_t;
  typedef logic [ROW_W-1:0]  row_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // Valid bit on top, then the bank whose word sits in the cache at that row
  typedef logic [BANK_W:0]   map_t;

endpackage

`default_nettype wire

/* hdl/bank_array.sv */
`timescale 1ns/10ps
`default_nettype none

module bank_array (
  input  wire logic           clk,
  input  wire logic           we,
  input  wire mem_pkg::row_t  wr_row,
  input  wire mem_pkg::data_t wr_data,
  input  wire mem_pkg::row_t  rd_row,
  output mem_pkg::data_t      rd_data
);

  mem_pkg::data_t mem [mem_pkg::NUM_ROWS];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_row] <= wr_data;
    end
    rd_data <= mem[rd_row]; // Sees the old word when the same row is written
  end

endmodule

`default_nettype wire

/* hdl/cache_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_bank (
  input  wire logic           clk,
  input  wire logic           we,
  input  wire mem_pkg::row_t  wr_row,
  input  wire mem_pkg::data_t wr_data,
  input  wire mem_pkg::row_t  rd_row,
  output mem_pkg::data_t      rd_data,
  input  wire mem_pkg::row_t  evict_row,
  output mem_pkg::data_t      evict_data
);

  mem_pkg::data_t mem [mem_pkg::NUM_ROWS];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_row] <= wr_data;
    end
    rd_data <= mem[rd_row];
  end

  // The displaced word has to reach its home bank in the same cycle it is replaced
  assign evict_data = mem[evict_row];

endmodule

`default_nettype wire

/* hdl/map_table.sv */
`timescale 1ns/10ps
`default_nettype none

module map_table (
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire logic          clr_a,
  input  wire mem_pkg::row_t clr_row_a,
  input  wire logic          upd_b,
  input  wire mem_pkg::row_t upd_row_b,
  input  wire mem_pkg::map_t upd_entry_b,
  input  wire mem_pkg::row_t look_row_a,
  input  wire mem_pkg::row_t look_row_b,
  input  wire mem_pkg::row_t look_row_rd,
  output mem_pkg::map_t      map_a,
  output mem_pkg::map_t      map_b,
  output mem_pkg::map_t      map_rd
);

  mem_pkg::map_t entries [mem_pkg::NUM_ROWS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < mem_pkg::NUM_ROWS; r++) begin
        entries[r] <= '0;
      end
    end else begin
      if (clr_a) begin
        entries[clr_row_a] <= '0;
      end
      if (upd_b) begin
        entries[upd_row_b] <= upd_entry_b; // Comes last so B wins on a shared row
      end
    end
  end

  assign map_a  = entries[look_row_a];
  assign map_b  = entries[look_row_b];
  assign map_rd = entries[look_row_rd];

endmodule

`default_nettype wire

/* hdl/write_steer.sv */
`timescale 1ns/10ps
`default_nettype none

module write_steer (
  input  wire logic                                  write_a,
  input  wire logic                                  write_b,
  input  wire mem_pkg::addr_t                        wr_adr_a,
  input  wire mem_pkg::addr_t                        wr_adr_b,
  input  wire mem_pkg::data_t                        din_a,
  input  wire mem_pkg::data_t                        din_b,
  input  wire mem_pkg::map_t                         map_a,
  input  wire mem_pkg::map_t                         map_b,
  input  wire mem_pkg::data_t                        evict_data,
  output mem_pkg::row_t                              row_a,
  output mem_pkg::row_t                              row_b,
  output logic [mem_pkg::NUM_BANKS-1:0]              bank_we,
  output mem_pkg::row_t [mem_pkg::NUM_BANKS-1:0]     bank_wr_row,
  output mem_pkg::data_t [mem_pkg::NUM_BANKS-1:0]    bank_wr_data,
  output logic                                       cache_we,
  output mem_pkg::row_t                              cache_wr_row,
  output mem_pkg::data_t                             cache_wr_data,
  output logic                                       clr_a,
  output mem_pkg::row_t                              clr_row_a,
  output logic                                       upd_b,
  output mem_pkg::row_t                              upd_row_b,
  output mem_pkg::map_t                              upd_entry_b
);

  mem_pkg::bank_t bank_a;
  mem_pkg::bank_t bank_b;
  mem_pkg::bank_t evict_bank;
  logic           conflict;
  logic           evict;
  logic           stale_b;

  assign bank_a = wr_adr_a[mem_pkg::BANK_W-1:0];
  assign bank_b = wr_adr_b[mem_pkg::BANK_W-1:0];
  assign row_a  = wr_adr_a[mem_pkg::ADDR_W-1:mem_pkg::BANK_W];
  assign row_b  = wr_adr_b[mem_pkg::ADDR_W-1:mem_pkg::BANK_W];

  assign conflict   = write_a && write_b && (bank_a == bank_b);
  assign evict_bank = map_b[mem_pkg::BANK_W-1:0];

  // Only the conflicting bank is busy, so the evicted word's home bank is always free
  assign evict   = conflict && map_b[mem_pkg::BANK_W] && (evict_bank != bank_b);
  assign stale_b = write_b && map_b[mem_pkg::BANK_W] && (evict_bank == bank_b);

  always_comb begin
    for (int b = 0; b < mem_pkg::NUM_BANKS; b++) begin
      bank_we[b]      = 1'b0;
      bank_wr_row[b]  = row_a;
      bank_wr_data[b] = din_a;
      if (write_a && (bank_a == mem_pkg::bank_t'(b))) begin
        bank_we[b] = 1'b1;
      end else if (write_b && !conflict && (bank_b == mem_pkg::bank_t'(b))) begin
        bank_we[b]      = 1'b1;
        bank_wr_row[b]  = row_b;
        bank_wr_data[b] = din_b;
      end else if (evict && (evict_bank == mem_pkg::bank_t'(b))) begin
        bank_we[b]      = 1'b1;
        bank_wr_row[b]  = row_b;
        bank_wr_data[b] = evict_data;
      end
    end
  end

  assign cache_we      = conflict;
  assign cache_wr_row  = row_b;
  assign cache_wr_data = din_b;

  // A home write makes a cached copy of the same word stale
  assign clr_a     = write_a && map_a[mem_pkg::BANK_W] &&
                     (map_a[mem_pkg::BANK_W-1:0] == bank_a);
  assign clr_row_a = row_a;

  assign upd_b       = conflict || stale_b;
  assign upd_row_b   = row_b;
  assign upd_entry_b = conflict ? {1'b1, bank_b} : '0;

endmodule

`default_nettype wire

/* hdl/read_port.sv */
`timescale 1ns/10ps
`default_nettype none

module read_port (
  input  wire logic                                clk,
  input  wire logic                                rst,
  input  wire logic                                read,
  input  wire mem_pkg::addr_t                      rd_adr,
  input  wire mem_pkg::map_t                       map_rd,
  input  wire mem_pkg::data_t [mem_pkg::NUM_BANKS-1:0] bank_rd_data,
  input  wire mem_pkg::data_t                      cache_rd_data,
  output mem_pkg::row_t                            rd_row,
  output logic                                     rd_vld,
  output mem_pkg::data_t                           rd_dout
);

  mem_pkg::bank_t rd_bank;
  mem_pkg::bank_t bank_q;
  logic           cache_hit;
  logic           cache_hit_q;

  assign rd_bank = rd_adr[mem_pkg::BANK_W-1:0];
  assign rd_row  = rd_adr[mem_pkg::ADDR_W-1:mem_pkg::BANK_W];

  assign cache_hit = map_rd[mem_pkg::BANK_W] && (map_rd[mem_pkg::BANK_W-1:0] == rd_bank);

  // The selection is taken along with the bank and cache reads, one cycle ahead of the data
  always_ff @(posedge clk) begin
    cache_hit_q <= cache_hit;
    bank_q      <= rd_bank;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= read;
    end
  end

  assign rd_dout = cache_hit_q ? cache_rd_data : bank_rd_data[bank_q];

endmodule

`default_nettype wire

/* hdl/mp_mem_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mp_mem_top (
  input  wire logic           clk,
  input  wire logic           rst,
  input  wire logic           write_a,
  input  wire mem_pkg::addr_t wr_adr_a,
  input  wire mem_pkg::data_t din_a,
  input  wire logic           write_b,
  input  wire mem_pkg::addr_t wr_adr_b,
  input  wire mem_pkg::data_t din_b,
  input  wire logic           read,
  input  wire mem_pkg::addr_t rd_adr,
  output logic                rd_vld,
  output mem_pkg::data_t      rd_dout
);

  mem_pkg::row_t                           row_a;
  mem_pkg::row_t                           row_b;
  mem_pkg::row_t                           rd_row;
  logic [mem_pkg::NUM_BANKS-1:0]           bank_we;
  mem_pkg::row_t [mem_pkg::NUM_BANKS-1:0]  bank_wr_row;
  mem_pkg::data_t [mem_pkg::NUM_BANKS-1:0] bank_wr_data;
  mem_pkg::data_t [mem_pkg::NUM_BANKS-1:0] bank_rd_data;
  logic                                    cache_we;
  mem_pkg::row_t                           cache_wr_row;
  mem_pkg::data_t                          cache_wr_data;
  mem_pkg::data_t                          cache_rd_data;
  mem_pkg::data_t                          evict_data;
  logic                                    clr_a;
  mem_pkg::row_t                           clr_row_a;
  logic                                    upd_b;
  mem_pkg::row_t                           upd_row_b;
  mem_pkg::map_t                           upd_entry_b;
  mem_pkg::map_t                           map_a;
  mem_pkg::map_t                           map_b;
  mem_pkg::map_t                           map_rd;

  for (genvar b = 0; b < mem_pkg::NUM_BANKS; b++) begin : g_bank
    bank_array bank_array_i (
      .clk     (clk),
      .we      (bank_we[b]),
      .wr_row  (bank_wr_row[b]),
      .wr_data (bank_wr_data[b]),
      .rd_row  (rd_row),
      .rd_data (bank_rd_data[b])
    );
  end

  cache_bank cache_bank_i (
    .clk        (clk),
    .we         (cache_we),
    .wr_row     (cache_wr_row),
    .wr_data    (cache_wr_data),
    .rd_row     (rd_row),
    .rd_data    (cache_rd_data),
    .evict_row  (row_b),
    .evict_data (evict_data)
  );

  map_table map_table_i (
    .clk         (clk),
    .rst         (rst),
    .clr_a       (clr_a),
    .clr_row_a   (clr_row_a),
    .upd_b       (upd_b),
    .upd_row_b   (upd_row_b),
    .upd_entry_b (upd_entry_b),
    .look_row_a  (row_a),
    .look_row_b  (row_b),
    .look_row_rd (rd_row),
    .map_a       (map_a),
    .map_b       (map_b),
    .map_rd      (map_rd)
  );

  write_steer write_steer_i (
    .write_a       (write_a),
    .write_b       (write_b),
    .wr_adr_a      (wr_adr_a),
    .wr_adr_b      (wr_adr_b),
    .din_a         (din_a),
    .din_b         (din_b),
    .map_a         (map_a),
    .map_b         (map_b),
    .evict_data    (evict_data),
    .row_a         (row_a),
    .row_b         (row_b),
    .bank_we       (bank_we),
    .bank_wr_row   (bank_wr_row),
    .bank_wr_data  (bank_wr_data),
    .cache_we      (cache_we),
    .cache_wr_row  (cache_wr_row),
    .cache_wr_data (cache_wr_data),
    .clr_a         (clr_a),
    .clr_row_a     (clr_row_a),
    .upd_b         (upd_b),
    .upd_row_b     (upd_row_b),
    .upd_entry_b   (upd_entry_b)
  );

  read_port read_port_i (
    .clk           (clk),
    .rst           (rst),
    .read          (read),
    .rd_adr        (rd_adr),
    .map_rd        (map_rd),
    .bank_rd_data  (bank_rd_data),
    .cache_rd_data (cache_rd_data),
    .rd_row        (rd_row),
    .rd_vld        (rd_vld),
    .rd_dout       (rd_dout)
  );

endmodule

`default_nettype wire

/* testbench/tb_mp_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mp_mem;

  localparam int NUM_ADDR   = mem_pkg::NUM_ROWS * mem_pkg::NUM_BANKS;
  localparam int MAX_CYCLES = 5000; // The tests need about 800 cycles after reset

  logic           clk;
  logic           rst;
  logic           write_a;
  mem_pkg::addr_t wr_adr_a;
  mem_pkg::data_t din_a;
  logic           write_b;
  mem_pkg::addr_t wr_adr_b;
  mem_pkg::data_t din_b;
  logic           read;
  mem_pkg::addr_t rd_adr;
  logic           rd_vld;
  mem_pkg::data_t rd_dout;

  mem_pkg::data_t shadow [NUM_ADDR]; // Expected contents, indexed by full address
  string          cur_test;
  logic           pend_read;
  mem_pkg::addr_t pend_adr;
  mem_pkg::data_t pend_exp;
  int             cycle_count = 0;

  mp_mem_top mp_mem_top_i (
    .clk      (clk),
    .rst      (rst),
    .write_a  (write_a),
    .wr_adr_a (wr_adr_a),
    .din_a    (din_a),
    .write_b  (write_b),
    .wr_adr_b (wr_adr_b),
    .din_b    (din_b),
    .read     (read),
    .rd_adr   (rd_adr),
    .rd_vld   (rd_vld),
    .rd_dout  (rd_dout)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Test FAILED");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  function automatic mem_pkg::addr_t make_addr(input int row, input int bank);
    return mem_pkg::addr_t'(row * mem_pkg::NUM_BANKS + bank); // Row above bank
  endfunction

  task automatic check(input string label, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s %s: expected %0h, actual %0h", cur_test, label, expected, actual);
      $display("Test FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // One cycle of stimulus, which also checks the read issued in the cycle before
  task automatic drive_cycle(input logic wa, input mem_pkg::addr_t adr_a,
                             input mem_pkg::data_t da, input logic wb,
                             input mem_pkg::addr_t adr_b, input mem_pkg::data_t db,
                             input logic rd, input mem_pkg::addr_t adr_rd);
    mem_pkg::data_t exp_rd;
    @(posedge clk);
    write_a  <= wa;
    wr_adr_a <= adr_a;
    din_a    <= da;
    write_b  <= wb;
    wr_adr_b <= adr_b;
    din_b    <= db;
    read     <= rd;
    rd_adr   <= adr_rd;
    exp_rd = shadow[adr_rd]; // A read sees the word from before this cycle's writes
    if (wa) shadow[adr_a] = da;
    if (wb) shadow[adr_b] = db; // Port B wins on a shared address
    @(negedge clk);
    check("rd_vld", 32'(pend_read), 32'(rd_vld));
    if (pend_read) check($sformatf("rd_dout @%0h", pend_adr), 32'(pend_exp), 32'(rd_dout));
    pend_read = rd;
    pend_adr  = adr_rd;
    pend_exp  = exp_rd;
  endtask

  task automatic idle();
    drive_cycle(1'b0, '0, '0, 1'b0, '0, '0, 1'b0, '0);
  endtask

  task automatic write_both(input mem_pkg::addr_t adr_a, input mem_pkg::data_t da,
                            input mem_pkg::addr_t adr_b, input mem_pkg::data_t db);
    drive_cycle(1'b1, adr_a, da, 1'b1, adr_b, db, 1'b0, '0);
  endtask

  task automatic read_check(input mem_pkg::addr_t adr);
    drive_cycle(1'b0, '0, '0, 1'b0, '0, '0, 1'b1, adr);
    idle(); // Result is checked here
  endtask

  task automatic read_all();
    for (int i = 0; i < NUM_ADDR; i++) begin
      drive_cycle(1'b0, '0, '0, 1'b0, '0, '0, 1'b1, mem_pkg::addr_t'(i));
    end
    idle();
  endtask

  task automatic reset_and_idle();
    cur_test = "reset_idle";
    @(negedge clk);
    check("rd_vld after reset", 32'd0, 32'(rd_vld));
    repeat (4) idle();
    drive_cycle(1'b1, make_addr(0, 0), 8'h3c, 1'b0, '0, '0, 1'b0, '0);
    read_check(make_addr(0, 0));
    repeat (3) idle();
  endtask

  task automatic write_each_port();
    cur_test = "single_writes";
    for (int i = 0; i < NUM_ADDR; i++) begin
      drive_cycle(1'b1, mem_pkg::addr_t'(i), mem_pkg::data_t'(i * 37 + 11),
                  1'b0, '0, '0, 1'b0, '0);
    end
    read_all();
    for (int i = 0; i < NUM_ADDR; i++) begin
      drive_cycle(1'b0, '0, '0, 1'b1, mem_pkg::addr_t'(i),
                  mem_pkg::data_t'(~(i * 53 + 5)), 1'b0, '0);
    end
    read_all();
  endtask

  task automatic write_distinct_banks();
    cur_test = "dual_writes";
    for (int r = 0; r < mem_pkg::NUM_ROWS; r++) begin
      write_both(make_addr(r, r % 4), mem_pkg::data_t'(r * 3 + 100),
                 make_addr(r, (r + 1) % 4), mem_pkg::data_t'(r * 5 + 7));
    end
    for (int r = 0; r < mem_pkg::NUM_ROWS; r++) begin
      write_both(make_addr(r, 2), mem_pkg::data_t'(r + 200),
                 make_addr(15 - r, 3), mem_pkg::data_t'(r * 11 + 1));
    end
    read_all();
  endtask

  task automatic force_conflicts();
    cur_test = "conflicts";
    for (int b = 0; b < mem_pkg::NUM_BANKS; b++) begin
      write_both(make_addr(2, b), mem_pkg::data_t'(192 + b), make_addr(5, b),
                 mem_pkg::data_t'(80 + b)); // Each step after the first evicts the previous bank
      read_check(make_addr(5, b));
    end
    drive_cycle(1'b1, make_addr(5, 3), 8'he7, 1'b0, '0, '0, 1'b0, '0);
    read_check(make_addr(5, 3));
    write_both(make_addr(0, 1), 8'h91, make_addr(9, 1), 8'h19);
    drive_cycle(1'b0, '0, '0, 1'b1, make_addr(9, 1), 8'h2b, 1'b0, '0);
    read_check(make_addr(9, 1));
    write_both(make_addr(3, 1), 8'h31, make_addr(11, 1), 8'h4d);
    write_both(make_addr(11, 1), 8'h6e, make_addr(4, 1), 8'h8f);
    read_check(make_addr(11, 1));
    read_all();
  endtask

  task automatic write_same_address();
    cur_test = "same_address";
    write_both(make_addr(10, 2), 8'h11, make_addr(10, 2), 8'h22);
    read_check(make_addr(10, 2));
    drive_cycle(1'b1, make_addr(8, 0), 8'ha5, 1'b0, '0, '0, 1'b1, make_addr(8, 0));
    read_check(make_addr(8, 0));
    drive_cycle(1'b1, make_addr(1, 3), 8'h5a, 1'b1, make_addr(6, 3), 8'hc3,
                1'b1, make_addr(6, 3));
    read_check(make_addr(6, 3));
  endtask

  task automatic random_traffic();
    cur_test = "random";
    for (int i = 0; i < 200; i++) begin
      drive_cycle(1'($urandom), mem_pkg::addr_t'($urandom), mem_pkg::data_t'($urandom),
                  1'($urandom), mem_pkg::addr_t'($urandom), mem_pkg::data_t'($urandom),
                  1'($urandom), mem_pkg::addr_t'($urandom));
    end
    idle();
    read_all();
  endtask

  initial begin
    void'($urandom(32'h4a32f77d));
    rst       = 1'b1;
    write_a   = 1'b0;
    wr_adr_a  = '0;
    din_a     = '0;
    write_b   = 1'b0;
    wr_adr_b  = '0;
    din_b     = '0;
    read      = 1'b0;
    rd_adr    = '0;
    pend_read = 1'b0;
    pend_adr  = '0;
    pend_exp  = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    reset_and_idle();
    write_each_port();
    write_distinct_banks();
    force_conflicts();
    write_same_address();
    random_traffic();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
hdl/mem_pkg.sv
hdl/bank_array.sv
hdl/cache_bank.sv
hdl/map_table.sv
hdl/write_steer.sv
hdl/read_port.sv
hdl/mp_mem_top.sv
testbench/tb_mp_mem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mp_mem
BUILD_DIR ?= obj_dir
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0
PASS_TEXT ?= Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The exit status comes from grep, so a missing pass line fails the target
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
